// ==== flist.f ====
rtl/adpll_pkg.sv
rtl/phase_accumulator.sv
rtl/loop_filter.sv
rtl/lock_detector.sv
rtl/acquisition_fsm.sv
rtl/dco_word_out.sv
rtl/adpll_ctrl.sv
testbench/adpll_ctrl_tb.sv

// ==== rtl/acquisition_fsm.sv ====
`timescale 1ns/1ps

module acquisition_fsm
   import adpll_pkg::*;
#(
   parameter int PU_TDC_CYCLES  = 16,
   parameter int PU_INJ_CYCLES  = 48,
   parameter int PU_DONE_CYCLES = 112,
   parameter int LOCK_CYCLES    = 480
) (
   input  logic        clk,
   input  logic        rst_accum_all,
   input  logic        en,
   input  fcw_t        fcw,
   input  adpll_mode_t adpll_mode,
   input  logic        lock_detect,
   output acq_state_t  state,
   output pwr_ctrl_t   pwr,
   output logic        accum_clear,
   output logic        lock_clear,
   output logic        lock_enable,
   output logic        bank_freeze,
   output logic        channel_lock
);

   localparam int CNT_MAX = (LOCK_CYCLES > PU_DONE_CYCLES) ? LOCK_CYCLES : PU_DONE_CYCLES;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);

   acq_state_t state_n;
   fcw_t fcw_q;
   adpll_mode_t mode_q;
   logic [CNT_W-1:0] time_cnt_q, time_cnt_n;
   pwr_ctrl_t pwr_n;
   logic accum_clear_n;
   logic channel_lock_n;

   ////////////////////
   // Detector control
   ////////////////////
   assign bank_freeze = lock_detect && ((state == C_L) || (state == C_M));
   // Medium-bank lock leaves the detector disabled, not cleared
   assign lock_clear  = (state == IDLE) || (state == PU) || ((state == C_L) && lock_detect);
   assign lock_enable = ((state == C_L) || (state == C_M)) && !accum_clear;

   ////////////////////
   // Next state
   ////////////////////
   always_comb begin
      state_n        = state;
      time_cnt_n     = time_cnt_q;
      pwr_n          = pwr;
      accum_clear_n  = 1'b0;
      channel_lock_n = channel_lock;
      if ((fcw != fcw_q) || (adpll_mode != mode_q)) begin
         state_n = IDLE;
      end else begin
         case (state)
            IDLE: begin
               time_cnt_n     = '0;
               channel_lock_n = 1'b0;
               if (adpll_mode == RX) begin
                  state_n      = PU;
                  pwr_n.dco_pd = 1'b0;
               end else begin
                  pwr_n = '1;
               end
            end
            PU: begin
               time_cnt_n = time_cnt_q + 1'b1;
               if (time_cnt_q == CNT_W'(PU_TDC_CYCLES - 1)) begin
                  pwr_n.tdc_pd = 1'b0;
               end
               if (time_cnt_q == CNT_W'(PU_INJ_CYCLES - 1)) begin
                  pwr_n.tdc_pd_inj = 1'b0;
               end
               if (time_cnt_q == CNT_W'(PU_DONE_CYCLES)) begin
                  state_n       = C_L;
                  accum_clear_n = 1'b1;
                  time_cnt_n    = '0;
               end
            end
            C_L: begin
               if (lock_detect) begin
                  state_n       = C_M;
                  accum_clear_n = 1'b1;
               end
            end
            C_M: begin
               if (lock_detect) begin
                  state_n       = C_S;
                  accum_clear_n = 1'b1;
               end
            end
            C_S: begin
               // Settling time for the small bank
               if (!channel_lock) begin
                  time_cnt_n = time_cnt_q + 1'b1;
                  if (time_cnt_q == CNT_W'(LOCK_CYCLES)) begin
                     channel_lock_n = 1'b1;
                  end
               end
            end
            default: state_n = IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst_accum_all) begin
         state        <= IDLE;
         time_cnt_q   <= '0;
         pwr          <= '1;
         accum_clear  <= 1'b0;
         channel_lock <= 1'b0;
         fcw_q        <= fcw;
         mode_q       <= adpll_mode;
      end else if (en) begin
         state        <= state_n;
         time_cnt_q   <= time_cnt_n;
         pwr          <= pwr_n;
         accum_clear  <= accum_clear_n;
         channel_lock <= channel_lock_n;
         fcw_q        <= fcw;
         mode_q       <= adpll_mode;
      end
   end

endmodule

// ==== rtl/adpll_ctrl.sv ====
`timescale 1ns/1ps

module adpll_ctrl
   import adpll_pkg::*;
#(
   parameter int PU_TDC_CYCLES     = 16,
   parameter int PU_INJ_CYCLES     = 48,
   parameter int PU_DONE_CYCLES    = 112,
   parameter int LOCK_CYCLES       = 480,
   parameter int LOCK_COUNT_FINE   = 15,
   parameter int LOCK_COUNT_COARSE = 8
) (
   input  logic        clk,
   input  logic        rst_accum_all,
   input  logic        en,
   input  fcw_t        fcw,
   input  adpll_mode_t adpll_mode,
   input  tdc_word_t   tdc_word,
   input  filter_cfg_t cfg,
   output dco_words_t  dco_words,
   output pwr_ctrl_t   pwr,
   output logic        channel_lock,
   output logic        channel_sat
);

   acq_state_t state;
   acc_t       ph_accum;
   otw_t       otw;
   otw_t       lock_word;
   logic       accum_clear;
   logic       lock_detect;
   logic       lock_clear;
   logic       lock_enable;
   logic       bank_freeze;

   ////////////////////
   // Sequencer
   ////////////////////
   acquisition_fsm #(
      .PU_TDC_CYCLES  (PU_TDC_CYCLES),
      .PU_INJ_CYCLES  (PU_INJ_CYCLES),
      .PU_DONE_CYCLES (PU_DONE_CYCLES),
      .LOCK_CYCLES    (LOCK_CYCLES)
   ) u_acq_fsm (
      .clk           (clk),
      .rst_accum_all (rst_accum_all),
      .en            (en),
      .fcw           (fcw),
      .adpll_mode    (adpll_mode),
      .lock_detect   (lock_detect),
      .state         (state),
      .pwr           (pwr),
      .accum_clear   (accum_clear),
      .lock_clear    (lock_clear),
      .lock_enable   (lock_enable),
      .bank_freeze   (bank_freeze),
      .channel_lock  (channel_lock)
   );

   ////////////////////
   // Datapath
   ////////////////////
   phase_accumulator u_ph_acc (
      .clk           (clk),
      .rst_accum_all (rst_accum_all),
      .en            (en),
      .accum_clear   (accum_clear),
      .fcw           (fcw),
      .tdc_word      (tdc_word),
      .ph_accum      (ph_accum)
   );

   loop_filter u_filter (
      .clk           (clk),
      .rst_accum_all (rst_accum_all),
      .en            (en),
      .accum_clear   (accum_clear),
      .state         (state),
      .cfg           (cfg),
      .ph_accum      (ph_accum),
      .otw           (otw)
   );

   lock_detector #(
      .LOCK_COUNT_FINE   (LOCK_COUNT_FINE),
      .LOCK_COUNT_COARSE (LOCK_COUNT_COARSE)
   ) u_lock_det (
      .clk           (clk),
      .rst_accum_all (rst_accum_all),
      .en            (en),
      .lock_clear    (lock_clear),
      .lock_enable   (lock_enable),
      .state         (state),
      .otw           (otw),
      .lock_detect   (lock_detect),
      .lock_word     (lock_word)
   );

   dco_word_out u_dco_out (
      .clk           (clk),
      .rst_accum_all (rst_accum_all),
      .en            (en),
      .state         (state),
      .accum_clear   (accum_clear),
      .bank_freeze   (bank_freeze),
      .otw           (otw),
      .lock_word     (lock_word),
      .dco_words     (dco_words),
      .channel_sat   (channel_sat)
   );

endmodule

// ==== rtl/adpll_pkg.sv ====
package adpll_pkg;

   ////////////////////
   // Word widths
   ////////////////////
   localparam int FCW_W     = 26;
   localparam int ACC_W     = 27;
   localparam int INT_W     = 12;
   localparam int FRA_W     = 14;
   // Filter output to tuning word scaling
   localparam int OTW_SHIFT = 7;

   // Signed capacitor bank limits
   localparam int L_MAX  = 12;
   localparam int L_MIN  = -13;
   localparam int MS_MAX = 127;
   localparam int MS_MIN = -128;

   typedef logic        [FCW_W-1:0] fcw_t;
   typedef logic        [INT_W-1:0] tdc_word_t;
   typedef logic signed [ACC_W-1:0] acc_t;
   typedef logic signed [7:0]       otw_t;
   typedef logic signed [4:0]       otw_l_t;

   // TEST and TX are decoded but behave like PD
   typedef enum logic [1:0] {
      PD   = 2'd0,
      TEST = 2'd1,
      RX   = 2'd2,
      TX   = 2'd3
   } adpll_mode_t;

   typedef enum logic [2:0] {
      IDLE = 3'd0,
      PU   = 3'd1,
      C_L  = 3'd2,
      C_M  = 3'd3,
      C_S  = 3'd4
   } acq_state_t;

   typedef struct packed {
      logic [3:0] alpha_l;
      logic [3:0] alpha_m;
      logic [3:0] alpha_s;
      logic [3:0] beta;     // zero turns the integral path off
      logic [2:0] lambda;
      logic [1:0] iir_n;
   } filter_cfg_t;

   typedef struct packed {
      otw_l_t c_l;
      otw_t   c_m;
      otw_t   c_s;
   } dco_words_t;

   typedef struct packed {
      logic dco_pd;
      logic tdc_pd;
      logic tdc_pd_inj;
   } pwr_ctrl_t;

endpackage

// ==== rtl/dco_word_out.sv ====
`timescale 1ns/1ps

module dco_word_out
   import adpll_pkg::*;
(
   input  logic       clk,
   input  logic       rst_accum_all,
   input  logic       en,
   input  acq_state_t state,
   input  logic       accum_clear,
   input  logic       bank_freeze,
   input  otw_t       otw,
   input  otw_t       lock_word,
   output dco_words_t dco_words,
   output logic       channel_sat
);

   otw_l_t frz_l_q;
   otw_t   frz_m_q;

   ////////////////////
   // Frozen bank words
   ////////////////////
   always_ff @(posedge clk) begin
      if (rst_accum_all) begin
         frz_l_q <= '0;
         frz_m_q <= '0;
      end else if (en) begin
         if (state == IDLE) begin
            frz_l_q <= '0;
            frz_m_q <= '0;
         end else if (bank_freeze) begin
            case (state)
               C_L:     frz_l_q <= otw_l_t'(lock_word);
               C_M:     frz_m_q <= lock_word;
               default: ;
            endcase
         end
      end
   end

   // Live word goes to the active bank once the clear cycle is over
   assign dco_words.c_l = ((state == C_L) && !accum_clear) ? otw_l_t'(otw) : frz_l_q;
   assign dco_words.c_m = ((state == C_M) && !accum_clear) ? otw : frz_m_q;
   // Small bank is never frozen and reads zero outside its own phase
   assign dco_words.c_s = ((state == C_S) && !accum_clear) ? otw : otw_t'(0);

   // Small bank at either rail
   assign channel_sat = (dco_words.c_s == otw_t'(MS_MAX)) ||
                        (dco_words.c_s == otw_t'(MS_MIN));

endmodule

// ==== rtl/lock_detector.sv ====
`timescale 1ns/1ps

module lock_detector
   import adpll_pkg::*;
#(
   parameter int LOCK_COUNT_FINE   = 15,
   parameter int LOCK_COUNT_COARSE = 8
) (
   input  logic       clk,
   input  logic       rst_accum_all,
   input  logic       en,
   input  logic       lock_clear,
   input  logic       lock_enable,
   input  acq_state_t state,
   input  otw_t       otw,
   output logic       lock_detect,
   output otw_t       lock_word
);

   otw_t cand1_q, cand2_q, cand1_n, cand2_n;
   otw_t lock_word_n;
   logic [4:0] cnt1_q, cnt2_q, cnt1_n, cnt2_n;
   logic [4:0] thr;
   logic lock_n;

   // Coarse bank settles on fewer repeats
   assign thr = (state == C_L) ? 5'(LOCK_COUNT_COARSE) : 5'(LOCK_COUNT_FINE);

   always_comb begin
      cand1_n     = cand1_q;
      cand2_n     = cand2_q;
      cnt1_n      = cnt1_q;
      cnt2_n      = cnt2_q;
      lock_n      = lock_detect;
      lock_word_n = lock_word;
      if (otw == cand1_q) begin
         cnt1_n = cnt1_q + 5'd1;
         if (cnt1_n == thr) begin
            lock_n      = 1'b1;
            lock_word_n = cand1_q;
         end
      end else if (otw == cand2_q) begin
         cnt2_n = cnt2_q + 5'd1;
         if (cnt2_n == thr) begin
            lock_n      = 1'b1;
            lock_word_n = cand2_q;
         end
      end else begin
         // New word pushes the older candidate down
         cand1_n = otw;
         cnt1_n  = 5'd1;
         cand2_n = cand1_q;
         cnt2_n  = cnt1_q;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_accum_all || (en && lock_clear)) begin
         cand1_q     <= '1;
         cand2_q     <= '1;
         cnt1_q      <= '0;
         cnt2_q      <= '0;
         lock_detect <= 1'b0;
         lock_word   <= '1;
      end else if (en && lock_enable && !lock_detect) begin
         cand1_q     <= cand1_n;
         cand2_q     <= cand2_n;
         cnt1_q      <= cnt1_n;
         cnt2_q      <= cnt2_n;
         lock_detect <= lock_n;
         lock_word   <= lock_word_n;
      end
   end

endmodule

// ==== rtl/loop_filter.sv ====
`timescale 1ns/1ps

module loop_filter
   import adpll_pkg::*;
(
   input  logic        clk,
   input  logic        rst_accum_all,
   input  logic        en,
   input  logic        accum_clear,
   input  acq_state_t  state,
   input  filter_cfg_t cfg,
   input  acc_t        ph_accum,
   output otw_t        otw
);

   acc_t iir1, iir2, iir3;
   acc_t iir1_q, iir2_q, iir3_q;
   acc_t iir_out;
   acc_t integral, integral_q, integral_sh;
   acc_t ntw, otw_full;
   logic [3:0] alpha;
   logic int_en;
   logic signed [ACC_W-FRA_W-1:0] otw_int;
   logic signed [ACC_W-FRA_W:0]   otw_rnd;
   int lim_hi, lim_lo;

   ////////////////////
   // IIR cascade
   ////////////////////
   assign iir1 = (ph_accum >>> cfg.lambda) - (iir1_q >>> cfg.lambda) + iir1_q;
   assign iir2 = (iir1 >>> cfg.lambda) - (iir2_q >>> cfg.lambda) + iir2_q;
   assign iir3 = (iir2 >>> cfg.lambda) - (iir3_q >>> cfg.lambda) + iir3_q;

   // Stage tap only used for the small bank
   always_comb begin
      iir_out = ph_accum;
      if (state == C_S) begin
         case (cfg.iir_n)
            2'd1:    iir_out = iir1;
            2'd2:    iir_out = iir2;
            2'd3:    iir_out = iir3;
            default: iir_out = ph_accum;
         endcase
      end
   end

   // Integral path
   assign integral    = iir_out + integral_q;
   assign integral_sh = integral >>> cfg.beta;
   assign int_en      = (state == C_S) && (cfg.beta != 4'd0);

   always_ff @(posedge clk) begin
      if (rst_accum_all) begin
         iir1_q     <= '0;
         iir2_q     <= '0;
         iir3_q     <= '0;
         integral_q <= '0;
      end else if (en) begin
         if (accum_clear) begin
            iir1_q     <= '0;
            iir2_q     <= '0;
            iir3_q     <= '0;
            integral_q <= iir_out;
         end else begin
            iir1_q     <= iir1;
            iir2_q     <= iir2;
            iir3_q     <= iir3;
            integral_q <= integral;
         end
      end
   end

   ////////////////////
   // Gain and quantizer
   ////////////////////
   always_comb begin
      case (state)
         C_L:     alpha = cfg.alpha_l;
         C_M:     alpha = cfg.alpha_m;
         default: alpha = cfg.alpha_s;
      endcase
   end

   assign ntw      = (iir_out >>> alpha) + (int_en ? integral_sh : acc_t'(0));
   assign otw_full = ntw <<< OTW_SHIFT;
   assign otw_int  = otw_full[ACC_W-1:FRA_W];
   // Round on the top fraction bit
   assign otw_rnd  = otw_int + $signed({1'b0, otw_full[FRA_W-1]});

   // Large bank has a narrower range
   assign lim_hi = (state == C_L) ? L_MAX : MS_MAX;
   assign lim_lo = (state == C_L) ? L_MIN : MS_MIN;

   always_comb begin
      if (otw_rnd > lim_hi) begin
         otw = otw_t'(lim_hi);
      end else if (otw_rnd < lim_lo) begin
         otw = otw_t'(lim_lo);
      end else begin
         otw = otw_t'(otw_rnd);
      end
   end

endmodule

// ==== rtl/phase_accumulator.sv ====
`timescale 1ns/1ps

module phase_accumulator
   import adpll_pkg::*;
(
   input  logic      clk,
   input  logic      rst_accum_all,
   input  logic      en,
   input  logic      accum_clear,
   input  fcw_t      fcw,
   input  tdc_word_t tdc_word,
   output acc_t      ph_accum
);

   acc_t ph_diff;
   acc_t fcw_ext;
   acc_t tdc_ext;

   // TDC word sits on the integer field of the FCW
   assign fcw_ext = acc_t'({1'b0, fcw});
   assign tdc_ext = acc_t'({1'b0, tdc_word, {FRA_W{1'b0}}});

   // Phase error per reference cycle
   assign ph_diff = fcw_ext - tdc_ext;

   ////////////////////
   // Accumulator
   ////////////////////
   always_ff @(posedge clk) begin
      if (rst_accum_all) begin
         ph_accum <= '0;
      end else if (en) begin
         if (accum_clear) begin
            ph_accum <= '0;
         end else begin
            ph_accum <= ph_accum + ph_diff;
         end
      end
   end

endmodule

// ==== testbench/adpll_ctrl_tb.sv ====
`timescale 1ns/1ps

module adpll_ctrl_tb
   import adpll_pkg::*;
();

   localparam int PU_TDC_CYCLES     = 16;
   localparam int PU_INJ_CYCLES     = 48;
   localparam int PU_DONE_CYCLES    = 112;
   localparam int LOCK_CYCLES       = 480;
   localparam int LOCK_COUNT_FINE   = 15;
   localparam int LOCK_COUNT_COARSE = 8;

   // Shortest possible path from RX to channel lock
   localparam int ACQ_MIN = PU_DONE_CYCLES + LOCK_CYCLES + LOCK_COUNT_COARSE + LOCK_COUNT_FINE;
   localparam int WATCHDOG_CYCLES = 4 * (ACQ_MIN + 160) + 200;

   logic        clk;
   logic        rst_accum_all;
   logic        en;
   fcw_t        fcw;
   adpll_mode_t adpll_mode;
   tdc_word_t   tdc_word;
   filter_cfg_t cfg;
   dco_words_t  dco_words;
   pwr_ctrl_t   pwr;
   logic        channel_lock;
   logic        channel_sat;

   logic [31:0] rng_state = 32'd86749;

   adpll_ctrl #(
      .PU_TDC_CYCLES     (PU_TDC_CYCLES),
      .PU_INJ_CYCLES     (PU_INJ_CYCLES),
      .PU_DONE_CYCLES    (PU_DONE_CYCLES),
      .LOCK_CYCLES       (LOCK_CYCLES),
      .LOCK_COUNT_FINE   (LOCK_COUNT_FINE),
      .LOCK_COUNT_COARSE (LOCK_COUNT_COARSE)
   ) DUT (
      .clk           (clk),
      .rst_accum_all (rst_accum_all),
      .en            (en),
      .fcw           (fcw),
      .adpll_mode    (adpll_mode),
      .tdc_word      (tdc_word),
      .cfg           (cfg),
      .dco_words     (dco_words),
      .pwr           (pwr),
      .channel_lock  (channel_lock),
      .channel_sat   (channel_sat)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////
   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
      if (actual !== expected) begin
         fail_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                            name, actual, expected));
      end
   endtask

   // Counts cycles from start_cycle until channel_lock rises
   task automatic lock_watch(input int start_cycle, input int min_cycles,
                             input int max_cycles, input logic expect_zero);
      int   cycles;
      logic locked;
      cycles = start_cycle;
      locked = 1'b0;
      while (!locked) begin
         @(negedge clk);
         cycles++;
         if (expect_zero) begin
            check_val("dco_words", dco_words, '0);
            check_val("channel_sat", channel_sat, 1'b0);
         end
         locked = channel_lock;
         if (!locked && cycles >= max_cycles) begin
            fail_run("channel_lock did not rise within the expected acquisition time");
         end
      end
      if (cycles < min_cycles) begin
         fail_run("channel_lock rose before the shortest possible acquisition time");
      end
   endtask

   ////////////////////
   // Tests
   ////////////////////
   task automatic reset_values();
      repeat (20) begin
         @(negedge clk);
         check_val("pwr", pwr, 3'b111);
         check_val("dco_words", dco_words, '0);
         check_val("channel_lock", channel_lock, 1'b0);
         check_val("channel_sat", channel_sat, 1'b0);
      end
   endtask

   task automatic power_up_sequence();
      int        active;
      int        held;
      int        hold_len;
      int        waited;
      pwr_ctrl_t exp_pwr;
      hold_len = 1 + (next_rand() % 8);
      @(posedge clk);
      adpll_mode <= RX;
      waited = 0;
      while (pwr.dco_pd !== 1'b0) begin
         @(negedge clk);
         waited++;
         if (waited > 8) begin
            fail_run("dco_pd never fell after switching to RX");
         end
      end
      check_val("pwr", pwr, 3'b011);
      active = 0;
      held   = 0;
      while (active < PU_INJ_CYCLES) begin
         @(posedge clk);
         if (en) begin
            active++;
         end
         // Clock enable gap in the middle of the count
         if (active == 8 && held < hold_len) begin
            en <= 1'b0;
            held++;
         end else begin
            en <= 1'b1;
         end
         @(negedge clk);
         exp_pwr.dco_pd     = 1'b0;
         exp_pwr.tdc_pd     = (active < PU_TDC_CYCLES);
         exp_pwr.tdc_pd_inj = (active < PU_INJ_CYCLES);
         check_val("pwr", pwr, exp_pwr);
         check_val("dco_words", dco_words, '0);
      end
   endtask

   task automatic clean_acquisition();
      logic [31:0]      r;
      logic [INT_W-1:0] int_field;
      filter_cfg_t      rnd_cfg;
      r = next_rand();
      int_field = r[INT_W-1:0];
      r = next_rand();
      rnd_cfg = filter_cfg_t'(r[$bits(filter_cfg_t)-1:0]);
      @(posedge clk);
      adpll_mode <= PD;
      fcw        <= {int_field, {FRA_W{1'b0}}};
      tdc_word   <= int_field;
      cfg        <= rnd_cfg;
      repeat (3) @(posedge clk);
      adpll_mode <= RX;
      lock_watch(0, ACQ_MIN, ACQ_MIN + 48, 1'b1);
      check_val("pwr", pwr, 3'b000);
   endtask

   task automatic saturated_acquisition();
      logic [31:0]      r;
      logic [INT_W-1:0] int_field;
      filter_cfg_t      sat_cfg;
      dco_words_t       exp_words;
      r = next_rand();
      int_field = INT_W'(16 + (r % 4000));
      sat_cfg.alpha_l = 4'd7;
      sat_cfg.alpha_m = 4'd7;
      sat_cfg.alpha_s = 4'd7;
      sat_cfg.beta    = 4'd0;
      sat_cfg.lambda  = 3'd0;
      sat_cfg.iir_n   = 2'd0;
      @(posedge clk);
      adpll_mode <= PD;
      fcw        <= {int_field, {FRA_W{1'b0}}};
      // Four integer steps of positive error per cycle
      tdc_word   <= int_field - INT_W'(4);
      cfg        <= sat_cfg;
      repeat (3) @(posedge clk);
      adpll_mode <= RX;
      lock_watch(0, ACQ_MIN, ACQ_MIN + 160, 1'b0);
      exp_words.c_l = otw_l_t'(L_MAX);
      exp_words.c_m = otw_t'(MS_MAX);
      exp_words.c_s = otw_t'(MS_MAX);
      check_val("dco_words", dco_words, exp_words);
      check_val("channel_sat", channel_sat, 1'b1);
   endtask

   task automatic restart_on_change();
      logic [31:0]      r;
      logic [INT_W-1:0] int_field;
      r = next_rand();
      int_field = r[INT_W-1:0];
      if ({int_field, {FRA_W{1'b0}}} == fcw) begin
         int_field = int_field + INT_W'(1);
      end
      @(posedge clk);
      fcw      <= {int_field, {FRA_W{1'b0}}};
      tdc_word <= int_field;
      repeat (3) @(negedge clk);
      check_val("channel_lock", channel_lock, 1'b0);
      check_val("dco_words", dco_words, '0);
      lock_watch(3, ACQ_MIN, ACQ_MIN + 48, 1'b1);
   endtask

   ////////////////////
   // Main sequence
   ////////////////////
   initial begin
      rst_accum_all = 1'b1;
      en            = 1'b1;
      fcw           = '0;
      adpll_mode    = PD;
      tdc_word      = '0;
      cfg           = '0;
      repeat (4) @(posedge clk);
      rst_accum_all <= 1'b0;
      reset_values();
      power_up_sequence();
      clean_acquisition();
      saturated_acquisition();
      restart_on_change();
      $display("Done: no errors");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      fail_run("Timeout: the tests did not finish in the expected time");
   end

endmodule
